//--- flist.f
common/sdram_pkg.sv
sdram_ctrl/sdram_wb_front.sv
sdram_ctrl/sdram_sched.sv
sdram_ctrl/sdram_io.sv
hdl/sdram_top.sv
sim/tb_clk.sv
sim/sdram_model.sv
sim/sdram_chk.sv
sim/sdram_tb.sv

//--- run.sh
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module sdram_tb -o sdram_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

# keep running after a checker error so the testbench can report it
./obj_dir/sdram_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1

//--- sim/sdram_tb.sv
module sdram_tb;

    localparam int t_init = 20;
    localparam int t_ref  = 120;
    localparam int t_rcd  = 3;
    localparam int xfer_limit = 200;
    localparam int n_init = 2;
    localparam int n_wr = 24;
    localparam int n_extra = 8;
    localparam int n_sel = 6;
    localparam int n_row = 8;
    localparam int n_keep = 4;
    localparam int n_busy = 10;
    localparam int n_xfer = n_init + 2 * n_wr + n_extra + 3 * n_sel + 2 * n_row + 2 * n_keep
                            + n_busy;
    localparam int wd_cycles = xfer_limit * n_xfer + t_init;

    logic        CLK, rst_n, cyc, stb, we, ack;
    logic [23:0] adr;
    logic [15:0] dat_w, dat_r;
    logic [1:0]  sel;
    wire  [15:0] dram_dq;
    logic [12:0] dram_addr;
    logic [1:0]  dram_ba, dram_dqm;
    logic        dram_cke, dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n;

    logic [15:0] ref_mem [logic [23:0]];
    int checks = 0;
    int errors = 0;
    int checks_at, errors_at;
    int cycle_cnt = 0;

    // last row opened in the bank under test
    logic        open_known = 1'b0;
    logic [12:0] open_row_exp;
    int          refs_seen = 0;

    tb_clk clk_inst (.CLK(CLK));

    sdram_top #(
        .cas(sdram_pkg::cas_3), .t_rcd(t_rcd), .t_init(t_init), .t_ref(t_ref)
    ) sdram_top_inst (
        .CLK, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .sel, .ack, .dat_r,
        .dram_dq, .dram_addr, .dram_ba, .dram_dqm, .dram_cke, .dram_cs_n,
        .dram_ras_n, .dram_cas_n, .dram_we_n
    );

    sdram_model #(.cl(3)) model_inst (
        .CLK, .cke(dram_cke), .cs_n(dram_cs_n), .ras_n(dram_ras_n), .cas_n(dram_cas_n),
        .we_n(dram_we_n), .ba(dram_ba), .addr(dram_addr), .dqm(dram_dqm), .dq(dram_dq)
    );

    bind sdram_io sdram_chk #(.t_rcd(3)) io_chk (
        .CLK(CLK), .rst_n(rst_n), .cs_n(dram_cs_n), .ras_n(dram_ras_n),
        .cas_n(dram_cas_n), .we_n(dram_we_n), .ba(dram_ba), .dq_oe(dq_oe)
    );

    always @(posedge CLK) cycle_cnt <= cycle_cnt + 1;

    initial begin
        repeat (wd_cycles) @(posedge CLK);
        $display("watchdog expired after %0d cycles, run aborted", wd_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [15:0] ref_word(input logic [23:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : 16'h0000;
    endfunction

    // wishbone sel picks which bytes of the new word land
    function automatic logic [15:0] merge_sel(input logic [15:0] old_w, input logic [15:0] new_w,
                                              input logic [1:0] s);
        return {s[1] ? new_w[15:8] : old_w[15:8], s[0] ? new_w[7:0] : old_w[7:0]};
    endfunction

    task automatic check_true(input string what, input logic ok);
        checks++;
        assert (ok) else begin
            $display("FAILED %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [23:0] a,
                              input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %0t: %s at adr %h read %h expected %h", $time, what, a, got, exp);
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge CLK);
    endtask

    task automatic bus_start(input logic w, input logic [23:0] a, input logic [15:0] d,
                             input logic [1:0] s);
        @(posedge CLK);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= w;
        adr   <= a;
        dat_w <= d;
        sel   <= s;
    endtask

    // stb drops on the edge that sees ack
    task automatic bus_finish(input logic [23:0] a, output logic [15:0] q);
        int n;
        n = 0;
        do begin
            @(posedge CLK);
            n++;
        end while (!ack && n < xfer_limit);
        q = dat_r;
        cyc <= 1'b0;
        stb <= 1'b0;
        if (!ack) begin
            $display("no ack for access at adr %h within %0d cycles", a, xfer_limit);
            errors++;
        end
    endtask

    // one classic cycle
    task automatic bus_cycle(input logic w, input logic [23:0] a, input logic [15:0] d,
                             input logic [1:0] s, output logic [15:0] q);
        bus_start(w, a, d, s);
        bus_finish(a, q);
    endtask

    task automatic bus_write(input logic [23:0] a, input logic [15:0] d, input logic [1:0] s);
        logic [15:0] q;
        bus_cycle(1'b1, a, d, s, q);
        ref_mem[a] = merge_sel(ref_word(a), d, s);
    endtask

    task automatic bus_read_check(input string what, input logic [23:0] a);
        logic [15:0] q;
        bus_cycle(1'b0, a, 16'h0000, 2'b11, q);
        check_word(what, a, q, ref_word(a));
    endtask

    // ACT count over one access follows the last row used in the bank
    task automatic row_access(input logic w, input logic [23:0] a, input logic [15:0] d);
        logic hit;
        int   acts;
        hit  = open_known && open_row_exp == a[21:9];
        acts = model_inst.act_cnt;
        if (w) bus_write(a, d, 2'b11);
        else bus_read_check("row access read", a);
        // a refresh in between closes every bank
        if (open_known && model_inst.ref_cnt == refs_seen) begin
            check_true(hit ? "ACT issued on a row hit" : "no single ACT on a row miss",
                       model_inst.act_cnt - acts == (hit ? 0 : 1));
        end
        open_known   = 1'b1;
        open_row_exp = a[21:9];
        refs_seen    = model_inst.ref_cnt;
    endtask

    task automatic test_start();
        checks_at = checks;
        errors_at = errors;
    endtask

    task automatic test_report(input string name);
        $display("test %s finished: %0d checks, %0d errors",
                 name, checks - checks_at, errors - errors_at);
    endtask

    initial begin
        int          n, start, refs, elapsed;
        logic [23:0] a;
        logic [15:0] d, q;
        logic [1:0]  s, b;
        logic [12:0] r0;
        logic [23:0] addr_q [$];
        logic [23:0] keep_q [$];
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        sel = '0;
        rst_n = 1'b0;
        void'($urandom(32'h67148b10));
        repeat (5) @(posedge CLK);
        rst_n <= 1'b1;

        // a write waits on the bus through the whole power-up sequence
        test_start();
        a = 24'($urandom);
        d = 16'($urandom);
        bus_start(1'b1, a, d, 2'b11);
        n = 0;
        while (!model_inst.mrs_seen && n < t_init + xfer_limit) begin
            check_true("ack raised before MRS", !ack);
            check_true("dq driven before MRS", !sdram_top_inst.io_inst.dq_oe);
            @(posedge CLK);
            n++;
        end
        check_true("MRS never appeared on the pins", model_inst.mrs_seen);
        check_true("MRS burst length is not 1", model_inst.mrs_addr[2:0] == 3'b000);
        check_true("MRS CAS latency is not 3", model_inst.mrs_addr[6:4] == 3'd3);
        check_true("MRS bank bits are not zero", model_inst.mrs_ba == 2'b00);
        bus_finish(a, q);
        ref_mem[a] = d;
        bus_read_check("write held through init", a);
        test_report("init");

        test_start();
        for (int i = 0; i < n_wr; i++) begin
            a = 24'($urandom);
            bus_write(a, 16'($urandom), 2'b11);
            addr_q.push_back(a);
        end
        for (int i = 0; i < n_extra; i++) addr_q.push_back(24'($urandom));
        foreach (addr_q[i]) bus_read_check("random read", addr_q[i]);
        test_report("random write and read");

        test_start();
        for (int i = 0; i < n_sel; i++) begin
            a = 24'($urandom);
            s = ($urandom & 1) ? 2'b01 : 2'b10;
            bus_write(a, 16'($urandom), 2'b11);
            bus_write(a, 16'($urandom), s);
            bus_read_check("byte select read", a);
        end
        test_report("byte select");

        test_start();
        b  = 2'($urandom);
        r0 = 13'($urandom);
        open_known = 1'b0;
        for (int i = 0; i < n_row; i++) begin
            a = {b, (i % 2 == 0) ? r0 : r0 + 13'(i), 9'($urandom)};
            row_access(1'b1, a, 16'($urandom));
            row_access(1'b0, a, 16'h0000);
        end
        test_report("row hit and miss");

        test_start();
        for (int i = 0; i < n_keep; i++) begin
            a = 24'($urandom);
            bus_write(a, 16'($urandom), 2'b11);
            keep_q.push_back(a);
        end
        start = cycle_cnt;
        refs  = model_inst.ref_cnt;
        for (int i = 0; i < n_busy; i++) begin
            idle_cycles(20 + $urandom % 40);
            bus_write(24'($urandom), 16'($urandom), 2'b11);
        end
        idle_cycles(240);
        elapsed = cycle_cnt - start;
        check_true("too few REFRESH commands over the stretch",
                   model_inst.ref_cnt - refs >= elapsed / t_ref - 1);
        foreach (keep_q[i]) bus_read_check("read after refresh", keep_q[i]);
        test_report("refresh");

        if (sdram_top_inst.io_inst.io_chk.fail_cnt != 0) begin
            $display("pin timing checker flagged %0d failures",
                     sdram_top_inst.io_inst.io_chk.fail_cnt);
            errors += sdram_top_inst.io_inst.io_chk.fail_cnt;
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim/sdram_chk.sv
module sdram_chk #(
    parameter int t_rcd = 3
) (
    input logic       CLK,
    input logic       rst_n,
    input logic       cs_n,
    input logic       ras_n,
    input logic       cas_n,
    input logic       we_n,
    input logic [1:0] ba,
    input logic       dq_oe
);

    logic [7:0] since_act [4];
    logic       act_cmd, col_cmd, wr_cmd;
    int         fail_cnt = 0;

    assign act_cmd = !cs_n && !ras_n && cas_n && we_n;
    assign col_cmd = !cs_n && ras_n && !cas_n;
    assign wr_cmd  = col_cmd && !we_n;

    // cycles since the last ACT seen on the pins, per bank
    always_ff @(posedge CLK) begin
        for (int b = 0; b < 4; b++) begin
            if (!rst_n) since_act[b] <= '1;
            else if (act_cmd && ba == 2'(b)) since_act[b] <= 8'd1;
            else if (since_act[b] != '1) since_act[b] <= since_act[b] + 8'd1;
        end
    end

    rcd_spacing: assert property (@(posedge CLK) disable iff (!rst_n)
        col_cmd |-> since_act[ba] >= t_rcd)
        else begin
            $error("column command on bank %0d closer than t_rcd to its ACT", ba);
            fail_cnt++;
        end

    dq_drive: assert property (@(posedge CLK) disable iff (!rst_n) dq_oe == wr_cmd)
        else begin
            $error("dq driver state does not match a WRITE on the pins");
            fail_cnt++;
        end

endmodule

//--- sim/sdram_model.sv
module sdram_model #(
    parameter int cl = 3
) (
    input  logic        CLK,
    input  logic        cke,
    input  logic        cs_n,
    input  logic        ras_n,
    input  logic        cas_n,
    input  logic        we_n,
    input  logic [1:0]  ba,
    input  logic [12:0] addr,
    input  logic [1:0]  dqm,
    inout  wire  [15:0] dq
);

    // storage keyed by bank, row, column, the same order as the bus address
    logic [15:0] mem [logic [23:0]];
    logic [3:0]  open_vld = '0;
    logic [12:0] open_row [4];
    logic [cl-1:0] rd_vld = '0;
    logic [15:0] rd_dat [cl];
    logic [23:0] cur;
    logic [15:0] old_word;
    int          act_cnt = 0;
    int          ref_cnt = 0;
    logic        mrs_seen = 1'b0;
    logic [1:0]  mrs_ba;
    logic [12:0] mrs_addr;

    // read data leaves the device cl edges after the READ is sampled
    assign dq = rd_vld[cl-1] ? rd_dat[cl-1] : 'z;

    always @(posedge CLK) begin
        rd_vld <= {rd_vld[cl-2:0], 1'b0};
        for (int i = cl - 1; i > 0; i--) begin
            rd_dat[i] <= rd_dat[i-1];
        end
        cur = {ba, open_row[ba], addr[8:0]};
        old_word = mem.exists(cur) ? mem[cur] : 16'h0000;
        if (cke && !cs_n) begin
            case ({ras_n, cas_n, we_n})
                3'b011: begin
                    open_vld[ba] <= 1'b1;
                    open_row[ba] <= addr;
                    act_cnt      <= act_cnt + 1;
                end
                3'b010: begin
                    if (addr[10]) open_vld <= '0;
                    else open_vld[ba] <= 1'b0;
                end
                3'b001: ref_cnt <= ref_cnt + 1;
                3'b000: begin
                    mrs_seen <= 1'b1;
                    mrs_ba   <= ba;
                    mrs_addr <= addr;
                end
                // dqm high masks its byte lane, a closed bank stores nothing
                3'b100: if (open_vld[ba]) begin
                    mem[cur] = {dqm[1] ? old_word[15:8] : dq[15:8],
                                dqm[0] ? old_word[7:0] : dq[7:0]};
                end
                3'b101: begin
                    rd_vld[0] <= 1'b1;
                    rd_dat[0] <= old_word;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- sim/tb_clk.sv
module tb_clk #(
    parameter int half_period = 5
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(half_period) CLK = ~CLK;
    end

endmodule

//--- hdl/sdram_top.sv
module sdram_top #(
    parameter sdram_pkg::cas_t cas = sdram_pkg::cas_3,
    parameter int t_rc   = 9,
    parameter int t_ras  = 6,
    parameter int t_rp   = 3,
    parameter int t_rcd  = 3,
    parameter int t_mrd  = 2,
    parameter int t_dpl  = 2,
    parameter int t_init = 14250,
    parameter int t_ref  = 1114
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [23:0] adr,
    input  logic [15:0] dat_w,
    input  logic [1:0]  sel,
    output logic        ack,
    output logic [15:0] dat_r,
    inout  wire  [15:0] dram_dq,
    output logic [12:0] dram_addr,
    output logic [1:0]  dram_ba,
    output logic [1:0]  dram_dqm,
    output logic        dram_cke,
    output logic        dram_cs_n,
    output logic        dram_ras_n,
    output logic        dram_cas_n,
    output logic        dram_we_n
);

    logic                         req, grant, ready, cke;
    sdram_pkg::op_t               req_op, cmd_op;
    logic [sdram_pkg::bank_w-1:0] req_bank, cmd_bank;
    logic [sdram_pkg::row_w-1:0]  req_row, cmd_addr;
    logic [sdram_pkg::col_w-1:0]  req_col;
    logic [1:0]                   req_dqm, cmd_dqm;
    sdram_pkg::payload_u          req_payload, cmd_payload;
    logic [15:0]                  rd_data;
    sdram_pkg::tag_t              rd_tag;

    sdram_wb_front front_inst (
        .CLK, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .sel, .grant, .rd_data, .rd_tag,
        .ack, .dat_r, .req, .req_op, .req_bank, .req_row, .req_col, .req_dqm, .req_payload
    );

    // ready stays internal, the front end simply waits on grant
    sdram_sched #(
        .cas(cas), .t_rc(t_rc), .t_ras(t_ras), .t_rp(t_rp), .t_rcd(t_rcd),
        .t_mrd(t_mrd), .t_dpl(t_dpl), .t_init(t_init), .t_ref(t_ref)
    ) sched_inst (
        .CLK, .rst_n, .req, .req_op, .req_bank, .req_row, .req_col, .req_dqm, .req_payload,
        .grant, .ready, .cke, .cmd_op, .cmd_addr, .cmd_bank, .cmd_dqm, .cmd_payload
    );

    sdram_io #(.cas(cas)) io_inst (
        .CLK, .rst_n, .cke, .cmd_op, .cmd_addr, .cmd_bank, .cmd_dqm, .cmd_payload,
        .rd_data, .rd_tag, .dram_dq, .dram_addr, .dram_ba, .dram_dqm, .dram_cke,
        .dram_cs_n, .dram_ras_n, .dram_cas_n, .dram_we_n
    );

endmodule

//--- sdram_ctrl/sdram_io.sv
module sdram_io #(
    parameter sdram_pkg::cas_t cas = sdram_pkg::cas_3
) (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                cke,
    input  sdram_pkg::op_t      cmd_op,
    input  logic [12:0]         cmd_addr,
    input  logic [1:0]          cmd_bank,
    input  logic [1:0]          cmd_dqm,
    input  sdram_pkg::payload_u cmd_payload,
    output logic [15:0]         rd_data,
    output sdram_pkg::tag_t     rd_tag,
    inout  wire  [15:0]         dram_dq,
    output logic [12:0]         dram_addr,
    output logic [1:0]          dram_ba,
    output logic [1:0]          dram_dqm,
    output logic                dram_cke,
    output logic                dram_cs_n,
    output logic                dram_ras_n,
    output logic                dram_cas_n,
    output logic                dram_we_n
);

    // one cycle out, cas latency in the device, one cycle in
    localparam int rd_lat = sdram_pkg::n_cas[cas] + 2;

    logic [15:0]                      dq_in, dq_out;
    logic                             dq_oe, dq_en;
    logic                             ras_n, cas_n, we_n;
    logic [12:0]                      addr_nxt;
    logic [1:0]                       ba_nxt, dqm_nxt;
    sdram_pkg::tag_t                  tag_in;
    sdram_pkg::tag_t [rd_lat-1:0]     tag_pipe;

    always_comb begin
        ras_n    = 1'b1;
        cas_n    = 1'b1;
        we_n     = 1'b1;
        dq_en    = 1'b0;
        dqm_nxt  = '0;
        tag_in   = '0;
        addr_nxt = cmd_addr;
        ba_nxt   = cmd_bank;
        case (cmd_op)
            sdram_pkg::op_ref: begin
                ras_n = 1'b0;
                cas_n = 1'b0;
            end
            sdram_pkg::op_pre: begin
                ras_n = 1'b0;
                we_n  = 1'b0;
            end
            sdram_pkg::op_act: ras_n = 1'b0;
            sdram_pkg::op_write: begin
                cas_n   = 1'b0;
                we_n    = 1'b0;
                dq_en   = 1'b1;
                dqm_nxt = cmd_dqm;
            end
            sdram_pkg::op_read: begin
                cas_n  = 1'b0;
                tag_in = cmd_payload.rd.tag;
            end
            sdram_pkg::op_mrs: begin
                ras_n    = 1'b0;
                cas_n    = 1'b0;
                we_n     = 1'b0;
                ba_nxt   = cmd_payload.mrs.ba;
                addr_nxt = cmd_payload.mrs.addr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            dram_cke   <= 1'b0;
            dram_cs_n  <= 1'b1;
            dram_ras_n <= 1'b1;
            dram_cas_n <= 1'b1;
            dram_we_n  <= 1'b1;
            dq_oe      <= 1'b0;
            tag_pipe   <= '0;
        end else begin
            dram_cke   <= cke;
            dram_cs_n  <= 1'b0;
            dram_ras_n <= ras_n;
            dram_cas_n <= cas_n;
            dram_we_n  <= we_n;
            dq_oe      <= dq_en;
            tag_pipe   <= {tag_pipe[rd_lat-2:0], tag_in};
        end
    end

    always_ff @(posedge CLK) begin
        dq_in     <= dram_dq;
        dq_out    <= cmd_payload.wdata;
        dram_addr <= addr_nxt;
        dram_ba   <= ba_nxt;
        dram_dqm  <= dqm_nxt;
    end

    assign dram_dq = dq_oe ? dq_out : 'z;
    assign rd_data = dq_in;
    assign rd_tag  = tag_pipe[rd_lat-1];

endmodule

//--- sdram_ctrl/sdram_sched.sv
module sdram_sched #(
    parameter sdram_pkg::cas_t cas = sdram_pkg::cas_3,
    parameter int t_rc   = 9,
    parameter int t_ras  = 6,
    parameter int t_rp   = 3,
    parameter int t_rcd  = 3,
    parameter int t_mrd  = 2,
    parameter int t_dpl  = 2,
    parameter int t_init = 14250,
    parameter int t_ref  = 1114
) (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic                         req,
    input  sdram_pkg::op_t               req_op,
    input  logic [sdram_pkg::bank_w-1:0] req_bank,
    input  logic [sdram_pkg::row_w-1:0]  req_row,
    input  logic [sdram_pkg::col_w-1:0]  req_col,
    input  logic [1:0]                   req_dqm,
    input  sdram_pkg::payload_u          req_payload,
    output logic                         grant,
    output logic                         ready,
    output logic                         cke,
    output sdram_pkg::op_t               cmd_op,
    output logic [sdram_pkg::row_w-1:0]  cmd_addr,
    output logic [sdram_pkg::bank_w-1:0] cmd_bank,
    output logic [1:0]                   cmd_dqm,
    output sdram_pkg::payload_u          cmd_payload
);

    localparam int n_bank  = 1 << sdram_pkg::bank_w;
    localparam int sp_w    = 8;
    localparam int tmr_max = (t_init > t_ref) ? t_init : t_ref;
    localparam int tmr_w   = $clog2(tmr_max + 1);

    localparam logic [3:0] s_init_wait = 4'd0;
    localparam logic [3:0] s_ref_pre   = 4'd1;
    localparam logic [3:0] s_ref       = 4'd2;
    localparam logic [3:0] s_mrs       = 4'd3;
    localparam logic [3:0] s_mrs_wait  = 4'd4;
    localparam logic [3:0] s_idle      = 4'd5;
    localparam logic [3:0] s_pre       = 4'd6;
    localparam logic [3:0] s_act       = 4'd7;
    localparam logic [3:0] s_col       = 4'd8;

    logic [3:0]                   state;
    logic [tmr_w-1:0]             tmr;
    logic                         ref_pend;
    logic                         ref_left;
    logic [n_bank-1:0]            open_vld;
    logic [sdram_pkg::row_w-1:0]  open_row [n_bank];
    logic [sp_w-1:0]              since_act, since_pre, since_wr, since_ref, since_mrs;
    logic                         pre_ok, act_ok, col_ok, ref_ok, mrs_ok, issue;
    sdram_pkg::op_t               op_nxt;
    logic [sdram_pkg::row_w-1:0]  addr_nxt;
    logic [sdram_pkg::bank_w-1:0] bank_nxt;
    logic [1:0]                   dqm_nxt;
    sdram_pkg::payload_u          pay_nxt;

    function automatic logic [sp_w-1:0] sat_inc(input logic [sp_w-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    // spacing is kept across all banks, conservative but simple
    assign pre_ok = (since_act >= t_ras) && (since_wr >= t_dpl);
    assign act_ok = (since_pre >= t_rp) && (since_act >= t_rc) && (since_ref >= t_rc);
    assign col_ok = since_act >= t_rcd;
    assign ref_ok = (since_pre >= t_rp) && (since_ref >= t_rc);
    assign mrs_ok = since_ref >= t_rc;
    assign issue  = op_nxt != sdram_pkg::op_nop;

    always_comb begin
        op_nxt   = sdram_pkg::op_nop;
        addr_nxt = '0;
        bank_nxt = req_bank;
        dqm_nxt  = '0;
        pay_nxt  = '0;
        case (state)
            s_ref_pre: if (pre_ok) begin
                op_nxt = sdram_pkg::op_pre;
                addr_nxt[sdram_pkg::pall_bit] = 1'b1;
            end
            s_ref: if (ref_ok) op_nxt = sdram_pkg::op_ref;
            s_mrs: if (mrs_ok) begin
                // burst length 1, sequential, cas latency in A[6:4]
                op_nxt = sdram_pkg::op_mrs;
                pay_nxt.mrs.addr[2:0] = sdram_pkg::bl_1;
                pay_nxt.mrs.addr[6:4] = 3'(sdram_pkg::n_cas[cas]);
            end
            s_pre: if (pre_ok) op_nxt = sdram_pkg::op_pre;
            s_act: if (act_ok) begin
                op_nxt   = sdram_pkg::op_act;
                addr_nxt = req_row;
            end
            s_col: if (col_ok) begin
                op_nxt   = req_op;
                addr_nxt = {{(sdram_pkg::row_w - sdram_pkg::col_w){1'b0}}, req_col};
                dqm_nxt  = req_dqm;
                pay_nxt  = req_payload;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= s_init_wait;
            tmr       <= '0;
            ref_pend  <= 1'b0;
            ref_left  <= 1'b0;
            open_vld  <= '0;
            grant     <= 1'b0;
            ready     <= 1'b0;
            cke       <= 1'b0;
            cmd_op    <= sdram_pkg::op_nop;
            since_act <= '1;
            since_pre <= '1;
            since_wr  <= '1;
            since_ref <= '1;
            since_mrs <= '1;
        end else begin
            cke    <= 1'b1;
            cmd_op <= op_nxt;
            grant  <= (state == s_col) && issue;

            since_act <= (op_nxt == sdram_pkg::op_act) ? sp_w'(1) : sat_inc(since_act);
            since_pre <= (op_nxt == sdram_pkg::op_pre) ? sp_w'(1) : sat_inc(since_pre);
            since_wr  <= (op_nxt == sdram_pkg::op_write) ? sp_w'(1) : sat_inc(since_wr);
            since_ref <= (op_nxt == sdram_pkg::op_ref) ? sp_w'(1) : sat_inc(since_ref);
            since_mrs <= (op_nxt == sdram_pkg::op_mrs) ? sp_w'(1) : sat_inc(since_mrs);

            // power-up wait, then a free running refresh period
            if (state == s_init_wait) begin
                tmr <= tmr + 1'b1;
                if (tmr >= t_init - 1) begin
                    tmr      <= '0;
                    ref_left <= 1'b1;
                    state    <= s_ref_pre;
                end
            end else if (tmr == tmr_w'(t_ref - 1)) begin
                tmr <= '0;
                if (ready) ref_pend <= 1'b1;
            end else begin
                tmr <= tmr + 1'b1;
            end

            case (state)
                s_ref_pre: if (issue) begin
                    open_vld <= '0;
                    state    <= s_ref;
                end
                s_ref: if (issue) begin
                    if (ready) begin
                        ref_pend <= 1'b0;
                        state    <= s_idle;
                    end else if (ref_left) begin
                        ref_left <= 1'b0;
                    end else begin
                        state <= s_mrs;
                    end
                end
                s_mrs: if (issue) state <= s_mrs_wait;
                s_mrs_wait: if (since_mrs >= t_mrd) begin
                    ready <= 1'b1;
                    state <= s_idle;
                end
                s_idle: if (ref_pend) begin
                    state <= (open_vld != '0) ? s_ref_pre : s_ref;
                end else if (req && !grant) begin
                    if (!open_vld[req_bank]) state <= s_act;
                    else if (open_row[req_bank] == req_row) state <= s_col;
                    else state <= s_pre;
                end
                s_pre: if (issue) begin
                    open_vld[req_bank] <= 1'b0;
                    state              <= s_act;
                end
                s_act: if (issue) begin
                    open_vld[req_bank] <= 1'b1;
                    state              <= s_col;
                end
                s_col: if (issue) state <= s_idle;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        cmd_addr    <= addr_nxt;
        cmd_bank    <= bank_nxt;
        cmd_dqm     <= dqm_nxt;
        cmd_payload <= pay_nxt;
        if (op_nxt == sdram_pkg::op_act) begin
            open_row[req_bank] <= req_row;
        end
    end

endmodule

//--- sdram_ctrl/sdram_wb_front.sv
module sdram_wb_front (
    input  logic                                CLK,
    input  logic                                rst_n,
    input  logic                                cyc,
    input  logic                                stb,
    input  logic                                we,
    input  logic [23:0]                         adr,
    input  logic [15:0]                         dat_w,
    input  logic [1:0]                          sel,
    input  logic                                grant,
    input  logic [15:0]                         rd_data,
    input  sdram_pkg::tag_t                     rd_tag,
    output logic                                ack,
    output logic [15:0]                         dat_r,
    output logic                                req,
    output sdram_pkg::op_t                      req_op,
    output logic [sdram_pkg::bank_w-1:0]        req_bank,
    output logic [sdram_pkg::row_w-1:0]         req_row,
    output logic [sdram_pkg::col_w-1:0]         req_col,
    output logic [1:0]                          req_dqm,
    output sdram_pkg::payload_u                 req_payload
);

    localparam logic [1:0] f_idle = 2'd0;
    localparam logic [1:0] f_req  = 2'd1;
    localparam logic [1:0] f_rd   = 2'd2;

    logic [1:0]      state;
    sdram_pkg::tag_t tag_cnt;
    logic            start;
    logic            tag_hit;

    // ack blocks a restart while the master is still dropping stb
    assign start   = (state == f_idle) && cyc && stb && !ack;
    assign tag_hit = (state == f_rd) && (rd_tag == req_payload.rd.tag);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state   <= f_idle;
            req     <= 1'b0;
            ack     <= 1'b0;
            tag_cnt <= 4'd1;
        end else begin
            ack <= 1'b0;
            case (state)
                f_idle: if (start) begin
                    req   <= 1'b1;
                    state <= f_req;
                    // tags wrap from 15 back to 1, never zero
                    if (!we) begin
                        tag_cnt <= (tag_cnt == 4'hf) ? 4'd1 : tag_cnt + 4'd1;
                    end
                end
                f_req: if (grant) begin
                    req <= 1'b0;
                    if (req_op == sdram_pkg::op_write) begin
                        ack   <= 1'b1;
                        state <= f_idle;
                    end else begin
                        state <= f_rd;
                    end
                end
                f_rd: if (tag_hit) begin
                    ack   <= 1'b1;
                    state <= f_idle;
                end
                default: state <= f_idle;
            endcase
        end
    end

    // request fields stay put until grant
    always_ff @(posedge CLK) begin
        if (start) begin
            req_op   <= we ? sdram_pkg::op_write : sdram_pkg::op_read;
            req_col  <= adr[sdram_pkg::col_w-1:0];
            req_row  <= adr[sdram_pkg::col_w +: sdram_pkg::row_w];
            req_bank <= adr[sdram_pkg::col_w + sdram_pkg::row_w +: sdram_pkg::bank_w];
            req_dqm  <= ~sel;
            if (we) begin
                req_payload.wdata <= dat_w;
            end else begin
                req_payload.rd.pad <= '0;
                req_payload.rd.tag <= tag_cnt;
            end
        end
        if (tag_hit) begin
            dat_r <= rd_data;
        end
    end

endmodule

//--- common/sdram_pkg.sv
package sdram_pkg;

    // one-hot controller operations, all zero is a NOP
    typedef logic [5:0] op_t;

    localparam op_t op_nop   = 6'b000000;
    localparam op_t op_ref   = 6'b000001;
    localparam op_t op_pre   = 6'b000010;
    localparam op_t op_act   = 6'b000100;
    localparam op_t op_write = 6'b001000;
    localparam op_t op_read  = 6'b010000;
    localparam op_t op_mrs   = 6'b100000;

    // cas latency selector and its cycle count
    typedef logic cas_t;

    localparam cas_t cas_2 = 1'b0;
    localparam cas_t cas_3 = 1'b1;

    localparam int n_cas [2] = '{2, 3};

    // device geometry
    localparam int row_w  = 13;
    localparam int bank_w = 2;
    localparam int col_w  = 9;

    // read tag, zero means no read in flight
    typedef logic [3:0] tag_t;

    // one command word, read as write data, read tag or mode value
    typedef union packed {
        logic [15:0] wdata;
        struct packed {
            logic [11:0] pad;
            tag_t        tag;
        } rd;
        struct packed {
            logic              pad;
            logic [bank_w-1:0] ba;
            logic [row_w-1:0]  addr;
        } mrs;
    } payload_u;

    // A10 on PRECHARGE closes every bank
    localparam int pall_bit = 10;

    // mode register burst length field for single word bursts
    localparam logic [2:0] bl_1 = 3'b000;

endpackage
